// File: include/storage_bus_defines.svh
// ------------------------------------------------------------
// Storage bus sizes and timing
// ------------------------------------------------------------

`ifndef STORAGE_BUS_DEFINES_SVH
`define STORAGE_BUS_DEFINES_SVH

// Width of one stored word
`define STORE_DATA_WIDTH 32

// Word address width
`define STORE_ADDR_WIDTH 4

// Number of words in the block store
`define STORE_DEPTH 16

// Minimum wait cycles per access
// The two low address bits add 0 to 3 on top
`define STORE_BASE_LATENCY 2

// Wait counter width
// Holds base latency plus 3
`define STORE_LAT_WIDTH 3

`endif

// File: logic/storage_bus_pkg.sv
// ------------------------------------------------------------
// Storage bus types
// ------------------------------------------------------------

`include "storage_bus_defines.svh"

package storage_bus_pkg;

  // Request from one master
  // Levels are held until the ready pulse
  typedef struct packed {
    logic                          rd;
    logic                          wr;
    logic [`STORE_ADDR_WIDTH-1:0]  addr;
    logic [`STORE_DATA_WIDTH-1:0]  wdata;
  } bus_req_t;

  // Arbiter owner
  // 2'b11 is never entered
  typedef enum logic [1:0] {
    LOCK_IDLE = 2'b00,
    LOCK_DATA = 2'b01,
    LOCK_INST = 2'b10
  } lock_state_e;

  // Block store sequencing
  typedef enum logic [1:0] {
    ST_IDLE = 2'b00,
    ST_WAIT = 2'b01,
    ST_DONE = 2'b10
  } store_state_e;

  // Decoded access
  // Write wins when both levels are high
  typedef enum logic {
    OP_READ  = 1'b0,
    OP_WRITE = 1'b1
  } store_op_e;

endpackage

// File: logic/bus_arbiter.sv
// ------------------------------------------------------------
// Two-master lock arbiter
// ------------------------------------------------------------

`timescale 1ns/100ps

`include "storage_bus_defines.svh"

module bus_arbiter import storage_bus_pkg::*; (
  input  logic                          Clock_in,
  input  logic                          arst_n,
  // Master side
  input  bus_req_t                      inst_req,
  input  bus_req_t                      data_req,
  // Store side
  input  logic                          store_ready,
  input  logic [`STORE_DATA_WIDTH-1:0]  store_rdata,
  output bus_req_t                      store_req,
  // Returns to masters
  output logic                          inst_ready,
  output logic                          data_ready,
  output logic [`STORE_DATA_WIDTH-1:0]  inst_rdata,
  output logic [`STORE_DATA_WIDTH-1:0]  data_rdata
);

  // Current owner and next owner
  lock_state_e bus_lock;
  lock_state_e lock_next;

  // 1 selects data port, 0 selects instruction port
  logic bus_select;
  logic select_next;

  // Master activity
  logic inst_act;
  logic data_act;

  // Request of the selected master before masking
  bus_req_t selected_req;

  assign inst_act = inst_req.rd | inst_req.wr;
  assign data_act = data_req.rd | data_req.wr;

  // ------------------------------------------------------------
  // Lock next state
  // ------------------------------------------------------------
  always_comb begin
    lock_next = bus_lock;
    // Ownership never moves during a completion pulse
    if (!store_ready) begin
      case (bus_lock)
        LOCK_IDLE: begin
          // Data wins a tie
          if (data_act) begin
            lock_next = LOCK_DATA;
          end else if (inst_act) begin
            lock_next = LOCK_INST;
          end
        end
        LOCK_DATA: begin
          // Held until the data master lets go
          if (!data_act) begin
            lock_next = inst_act ? LOCK_INST : LOCK_IDLE;
          end
        end
        LOCK_INST: begin
          if (!inst_act) begin
            lock_next = data_act ? LOCK_DATA : LOCK_IDLE;
          end
        end
        default: begin
          lock_next = LOCK_IDLE;
        end
      endcase
    end
  end

  // Select follows the new owner, holds when going idle
  always_comb begin
    select_next = bus_select;
    case (lock_next)
      LOCK_DATA: select_next = 1'b1;
      LOCK_INST: select_next = 1'b0;
      default:   select_next = bus_select;
    endcase
  end

  always_ff @(posedge Clock_in or negedge arst_n) begin
    if (!arst_n) begin
      bus_lock   <= LOCK_IDLE;
      bus_select <= 1'b0;
    end else begin
      bus_lock   <= lock_next;
      bus_select <= select_next;
    end
  end

  // ------------------------------------------------------------
  // Request mux and return routing
  // ------------------------------------------------------------
  assign selected_req = bus_select ? data_req : inst_req;

  // No access reaches the store until a grant is registered
  always_comb begin
    store_req = selected_req;
    if (bus_lock == LOCK_IDLE) begin
      store_req.rd = 1'b0;
      store_req.wr = 1'b0;
    end
  end

  // Ready only to the owner
  assign inst_ready = store_ready & ~bus_select;
  assign data_ready = store_ready &  bus_select;

  // Read data mirrored to both ports
  assign inst_rdata = store_rdata;
  assign data_rdata = store_rdata;

endmodule

// File: logic/block_store.sv
// ------------------------------------------------------------
// Register-file block store
// ------------------------------------------------------------

`timescale 1ns/100ps

`include "storage_bus_defines.svh"

module block_store import storage_bus_pkg::*; (
  input  logic                          Clock_in,
  input  logic                          arst_n,
  input  bus_req_t                      store_req,
  output logic                          store_ready,
  output logic [`STORE_DATA_WIDTH-1:0]  store_rdata
);

  // Sequencer state
  store_state_e state;

  // Latched access
  store_op_e                     op_q;
  logic [`STORE_ADDR_WIDTH-1:0]  addr_q;
  logic [`STORE_DATA_WIDTH-1:0]  wdata_q;

  // Remaining wait cycles minus one
  logic [`STORE_LAT_WIDTH-1:0]   wait_cnt;

  // Storage array and read register
  logic [`STORE_DATA_WIDTH-1:0]  mem [`STORE_DEPTH];
  logic [`STORE_DATA_WIDTH-1:0]  rdata_q;

  // Decode of the incoming request
  logic                          req_valid;
  store_op_e                     req_op;
  logic [`STORE_LAT_WIDTH-1:0]   lat_load;

  // Last wait cycle
  // The access happens at its closing edge
  logic                          access_go;

  // ------------------------------------------------------------
  // Request decode
  // ------------------------------------------------------------
  assign req_valid = store_req.rd | store_req.wr;

  // Write wins when both levels are high
  always_comb begin
    if (store_req.wr) begin
      req_op = OP_WRITE;
    end else begin
      req_op = OP_READ;
    end
  end

  // Base latency plus low address bits as a down count to zero
  assign lat_load = `STORE_LAT_WIDTH'(`STORE_BASE_LATENCY - 1)
                  + `STORE_LAT_WIDTH'(store_req.addr[1:0]);

  assign access_go = (state == ST_WAIT) && (wait_cnt == '0);

  // ------------------------------------------------------------
  // Sequencer
  // ------------------------------------------------------------
  always_ff @(posedge Clock_in or negedge arst_n) begin
    if (!arst_n) begin
      state    <= ST_IDLE;
      op_q     <= OP_READ;
      wait_cnt <= '0;
    end else begin
      case (state)
        ST_IDLE: begin
          // Take any request with a level high
          if (req_valid) begin
            op_q     <= req_op;
            wait_cnt <= lat_load;
            state    <= ST_WAIT;
          end
        end
        ST_WAIT: begin
          if (wait_cnt == '0) begin
            state <= ST_DONE;
          end else begin
            wait_cnt <= wait_cnt - 1'b1;
          end
        end
        ST_DONE: begin
          // Single ready cycle
          state <= ST_IDLE;
        end
        default: begin
          state <= ST_IDLE;
        end
      endcase
    end
  end

  // Address and data payload
  always_ff @(posedge Clock_in) begin
    if (state == ST_IDLE && req_valid) begin
      addr_q  <= store_req.addr;
      wdata_q <= store_req.wdata;
    end
  end

  // ------------------------------------------------------------
  // Storage array
  // ------------------------------------------------------------
  always_ff @(posedge Clock_in or negedge arst_n) begin
    if (!arst_n) begin
      for (int i = 0; i < `STORE_DEPTH; i++) begin
        mem[i] <= '0;
      end
      rdata_q <= '0;
    end else if (access_go) begin
      if (op_q == OP_WRITE) begin
        mem[addr_q] <= wdata_q;
      end else begin
        // Held until the next read completes
        rdata_q <= mem[addr_q];
      end
    end
  end

  // Ready lines up with fresh read data
  assign store_ready = (state == ST_DONE);
  assign store_rdata = rdata_q;

endmodule

// File: logic/storage_bus_top.sv
// ------------------------------------------------------------
// Storage bus top level
// ------------------------------------------------------------

`timescale 1ns/100ps

`include "storage_bus_defines.svh"

module storage_bus_top import storage_bus_pkg::*; (
  input  logic                          Clock_in,
  input  logic                          arst_n,
  // Master requests
  input  bus_req_t                      inst_req,
  input  bus_req_t                      data_req,
  // Completion pulses
  output logic                          inst_ready,
  output logic                          data_ready,
  // Read data, same word on both
  output logic [`STORE_DATA_WIDTH-1:0]  inst_rdata,
  output logic [`STORE_DATA_WIDTH-1:0]  data_rdata
);

  // Arbiter to store
  bus_req_t                      store_req;

  // Store back to arbiter
  logic                          store_ready;
  logic [`STORE_DATA_WIDTH-1:0]  store_rdata;

  // ------------------------------------------------------------
  // Arbiter
  // ------------------------------------------------------------
  bus_arbiter u_bus_arbiter (
    .Clock_in    (Clock_in),
    .arst_n      (arst_n),
    .inst_req    (inst_req),
    .data_req    (data_req),
    .store_ready (store_ready),
    .store_rdata (store_rdata),
    .store_req   (store_req),
    .inst_ready  (inst_ready),
    .data_ready  (data_ready),
    .inst_rdata  (inst_rdata),
    .data_rdata  (data_rdata)
  );

  // ------------------------------------------------------------
  // Block store
  // ------------------------------------------------------------
  block_store u_block_store (
    .Clock_in    (Clock_in),
    .arst_n      (arst_n),
    .store_req   (store_req),
    .store_ready (store_ready),
    .store_rdata (store_rdata)
  );

endmodule

// File: verif/clock_gen.sv
// ------------------------------------------------------------
// Testbench clock and reset
// ------------------------------------------------------------

`timescale 1ns/100ps

module clock_gen #(
  parameter int HALF_PERIOD  = 2,
  parameter int RESET_CYCLES = 4
) (
  output logic Clock_in,
  output logic arst_n
);

  // 4 ns period
  initial begin
    Clock_in = 1'b0;
    forever #(HALF_PERIOD) Clock_in = ~Clock_in;
  end

  // Reset held low for a few rising edges, then released on an edge
  initial begin
    arst_n = 1'b0;
    repeat (RESET_CYCLES) @(posedge Clock_in);
    arst_n <= 1'b1;
  end

endmodule

// File: verif/storage_bus_checker.sv
// ------------------------------------------------------------
// Storage bus checker
// ------------------------------------------------------------

`timescale 1ns/100ps

`include "storage_bus_defines.svh"

module storage_bus_checker import storage_bus_pkg::*; (
  input  logic                          Clock_in,
  input  logic                          arst_n,
  input  bus_req_t                      inst_req,
  input  bus_req_t                      data_req,
  input  logic                          inst_ready,
  input  logic                          data_ready,
  input  logic [`STORE_DATA_WIDTH-1:0]  inst_rdata,
  input  logic [`STORE_DATA_WIDTH-1:0]  data_rdata,
  input  logic [7:0]                    test_id,
  input  logic                          both_line,
  input  logic [`STORE_DATA_WIDTH-1:0]  exp_inst,
  input  logic [`STORE_DATA_WIDTH-1:0]  exp_data,
  input  logic                          test_done,
  input  logic                          run_done,
  output int                            err_count
);

  // Reference memory starting from zero
  logic [`STORE_DATA_WIDTH-1:0] ref_mem [`STORE_DEPTH];
  int   line_err;
  int   tests_run;
  int   tests_failed;
  logic seen_data;
  logic reset_checked;
  logic counts_printed;

  task automatic compare_word(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
    if (got !== exp) begin
      $display("CHECK FAILED %s: got %h expected %h (test %0d)", name, got, exp, test_id);
      err_count++;
      line_err++;
    end
  endtask

  task automatic report_problem(input string what);
    $display("Test %0d: %s", test_id, what);
    err_count++;
    line_err++;
  endtask

  initial begin
    for (int i = 0; i < `STORE_DEPTH; i++) begin
      ref_mem[i] = '0;
    end
    err_count      = 0;
    line_err       = 0;
    tests_run      = 0;
    tests_failed   = 0;
    seen_data      = 1'b0;
    reset_checked  = 1'b0;
    counts_printed = 1'b0;
  end

  always @(posedge Clock_in) begin
    if (arst_n) begin
      // Outputs right after reset
      if (!reset_checked) begin
        compare_word("inst_ready", 32'(inst_ready), 32'h0);
        compare_word("data_ready", 32'(data_ready), 32'h0);
        compare_word("inst_rdata", inst_rdata, 32'h0);
        compare_word("data_rdata", data_rdata, 32'h0);
        reset_checked = 1'b1;
      end
      // Mirror check on every completion
      if (inst_ready || data_ready) begin
        compare_word("data_rdata", data_rdata, inst_rdata);
      end
      if (data_ready) begin
        seen_data = 1'b1;
        if (data_req.wr) begin
          ref_mem[data_req.addr] = data_req.wdata;
        end else if (data_req.rd) begin
          compare_word("data_rdata", data_rdata, ref_mem[data_req.addr]);
          compare_word("data_rdata", data_rdata, exp_data);
        end else begin
          report_problem("data port got a ready without a request");
        end
      end
      if (inst_ready) begin
        // Data wins a tie from idle
        if (both_line && !seen_data) begin
          report_problem("instruction port was served before the data port");
        end
        if (inst_req.wr) begin
          ref_mem[inst_req.addr] = inst_req.wdata;
        end else if (inst_req.rd) begin
          compare_word("inst_rdata", inst_rdata, ref_mem[inst_req.addr]);
          compare_word("inst_rdata", inst_rdata, exp_inst);
        end else begin
          report_problem("instruction port got a ready without a request");
        end
      end
      if (test_done) begin
        tests_run++;
        if (line_err == 0) begin
          $display("Test %0d ok", test_id);
        end else begin
          $display("Test %0d FAILED with %0d errors", test_id, line_err);
          tests_failed++;
        end
        line_err  = 0;
        seen_data = 1'b0;
      end
      if (run_done && !counts_printed) begin
        $display("Tests run %0d, tests failed %0d, check errors %0d",
                 tests_run, tests_failed, err_count);
        counts_printed = 1'b1;
      end
    end
  end

endmodule

// File: verif/storage_bus_sva.sv
// ------------------------------------------------------------
// Arbiter assertions
// ------------------------------------------------------------

`timescale 1ns/100ps

`include "storage_bus_defines.svh"

module storage_bus_sva import storage_bus_pkg::*; (
  input logic                          Clock_in,
  input logic                          arst_n,
  input bus_req_t                      inst_req,
  input bus_req_t                      data_req,
  input logic                          store_ready,
  input logic                          inst_ready,
  input logic                          data_ready,
  input logic [`STORE_DATA_WIDTH-1:0]  inst_rdata,
  input logic [`STORE_DATA_WIDTH-1:0]  data_rdata,
  input lock_state_e                   bus_lock
);

  // Number of failed assertions
  int assert_fails;

  initial begin
    assert_fails = 0;
  end

  // Ready only to the lock owner and so never to both ports
  a_inst_owner: assert property (@(posedge Clock_in) disable iff (!arst_n)
    inst_ready |-> (bus_lock == LOCK_INST))
    else begin
      $error("inst_ready while the instruction port does not hold the lock");
      assert_fails++;
    end

  a_data_owner: assert property (@(posedge Clock_in) disable iff (!arst_n)
    data_ready |-> (bus_lock == LOCK_DATA))
    else begin
      $error("data_ready while the data port does not hold the lock");
      assert_fails++;
    end

  a_inst_ready_req: assert property (@(posedge Clock_in) disable iff (!arst_n)
    inst_ready |-> (inst_req.rd || inst_req.wr))
    else begin
      $error("inst_ready without request");
      assert_fails++;
    end

  a_data_ready_req: assert property (@(posedge Clock_in) disable iff (!arst_n)
    data_ready |-> (data_req.rd || data_req.wr))
    else begin
      $error("data_ready without request");
      assert_fails++;
    end

  a_no_x: assert property (@(posedge Clock_in) disable iff (!arst_n)
    !$isunknown({inst_ready, data_ready, inst_rdata, data_rdata}))
    else begin
      $error("unknown value on outputs");
      assert_fails++;
    end

  // Ownership frozen across the ready pulse
  a_lock_stable: assert property (@(posedge Clock_in) disable iff (!arst_n)
    store_ready |=> $stable(bus_lock))
    else begin
      $error("lock changed during ready");
      assert_fails++;
    end

endmodule

bind bus_arbiter storage_bus_sva u_storage_bus_sva (
  .Clock_in    (Clock_in),
  .arst_n      (arst_n),
  .inst_req    (inst_req),
  .data_req    (data_req),
  .store_ready (store_ready),
  .inst_ready  (inst_ready),
  .data_ready  (data_ready),
  .inst_rdata  (inst_rdata),
  .data_rdata  (data_rdata),
  .bus_lock    (bus_lock)
);

// File: verif/storage_bus_tb.sv
// ------------------------------------------------------------
// Storage bus testbench top
// ------------------------------------------------------------

`timescale 1ns/100ps

`include "storage_bus_defines.svh"

module storage_bus_tb import storage_bus_pkg::*; ();

  // Pattern lines in the data file
  localparam int NUM_PATTERNS = 24;
  localparam int PAT_WIDTH    = 156;
  // Worst case per line is two accesses plus the idle gap
  localparam int TIMEOUT_CYCLES =
    NUM_PATTERNS * 2 * (`STORE_BASE_LATENCY + 3 + 3) + 20;

  logic                          Clock_in;
  logic                          arst_n;
  bus_req_t                      inst_req;
  bus_req_t                      data_req;
  logic                          inst_ready;
  logic                          data_ready;
  logic [`STORE_DATA_WIDTH-1:0]  inst_rdata;
  logic [`STORE_DATA_WIDTH-1:0]  data_rdata;

  // Test progress towards the checker
  logic [7:0]                    test_id;
  logic                          both_line;
  logic [`STORE_DATA_WIDTH-1:0]  exp_inst;
  logic [`STORE_DATA_WIDTH-1:0]  exp_data;
  logic                          test_done;
  logic                          run_done;
  int                            err_count;

  logic [PAT_WIDTH-1:0]          patterns [NUM_PATTERNS];
  int                            cycle_cnt;

  clock_gen u_clock_gen (
    .Clock_in (Clock_in),
    .arst_n   (arst_n)
  );

  storage_bus_top UUT (
    .Clock_in   (Clock_in),
    .arst_n     (arst_n),
    .inst_req   (inst_req),
    .data_req   (data_req),
    .inst_ready (inst_ready),
    .data_ready (data_ready),
    .inst_rdata (inst_rdata),
    .data_rdata (data_rdata)
  );

  storage_bus_checker u_checker (
    .Clock_in   (Clock_in),
    .arst_n     (arst_n),
    .inst_req   (inst_req),
    .data_req   (data_req),
    .inst_ready (inst_ready),
    .data_ready (data_ready),
    .inst_rdata (inst_rdata),
    .data_rdata (data_rdata),
    .test_id    (test_id),
    .both_line  (both_line),
    .exp_inst   (exp_inst),
    .exp_data   (exp_data),
    .test_done  (test_done),
    .run_done   (run_done),
    .err_count  (err_count)
  );

  // Op code 1 is a write, 0 a read
  function automatic bus_req_t make_request(input logic [3:0] op, input logic [3:0] addr,
                                            input logic [31:0] wdata);
    bus_req_t r;
    r.rd    = (op == 4'h0);
    r.wr    = (op == 4'h1);
    r.addr  = addr[`STORE_ADDR_WIDTH-1:0];
    r.wdata = wdata;
    return r;
  endfunction

  // ------------------------------------------------------------
  // One pattern line started at a rising edge
  // ------------------------------------------------------------
  task automatic run_line(input logic [PAT_WIDTH-1:0] p);
    logic use_inst;
    logic use_data;
    logic inst_done;
    logic data_done;
    use_inst  = p[144];
    use_data  = p[145];
    test_id   <= p[155:148];
    both_line <= use_inst & use_data;
    exp_inst  <= p[103:72];
    exp_data  <= p[31:0];
    if (use_inst) begin
      inst_req <= make_request(p[143:140], p[139:136], p[135:104]);
    end
    if (use_data) begin
      data_req <= make_request(p[71:68], p[67:64], p[63:32]);
    end
    inst_done = !use_inst;
    data_done = !use_data;
    // Levels held until each ready is seen at an edge
    while (!(inst_done && data_done)) begin
      @(posedge Clock_in);
      if (!inst_done && inst_ready) begin
        inst_req  <= '0;
        inst_done = 1'b1;
      end
      if (!data_done && data_ready) begin
        data_req  <= '0;
        data_done = 1'b1;
      end
    end
    test_done <= 1'b1;
    @(posedge Clock_in);
    test_done <= 1'b0;
  endtask

  initial begin
    inst_req  = '0;
    data_req  = '0;
    test_id   = '0;
    both_line = 1'b0;
    exp_inst  = '0;
    exp_data  = '0;
    test_done = 1'b0;
    run_done  = 1'b0;
    void'($urandom(38));
    $readmemh("verif/storage_bus_patterns.txt", patterns);
    wait (arst_n === 1'b1);
    @(posedge Clock_in);
    for (int i = 0; i < NUM_PATTERNS; i++) begin
      // Random idle gap of 0 to 3 cycles
      repeat ($urandom % 4) @(posedge Clock_in);
      run_line(patterns[i]);
    end
    run_done <= 1'b1;
    repeat (2) @(posedge Clock_in);
    if (err_count == 0 && UUT.u_bus_arbiter.u_storage_bus_sva.assert_fails == 0) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  end

  // Run limit
  initial begin
    cycle_cnt = 0;
    while (cycle_cnt <= TIMEOUT_CYCLES) begin
      @(posedge Clock_in);
      cycle_cnt++;
    end
    $display("Timeout after %0d cycles while test %0d was still waiting for ready",
             cycle_cnt, test_id);
    $display("Testbench failed");
    $finish;
  end

endmodule

// File: verif/storage_bus_patterns.txt
// id _ ports(1 inst,2 data,3 both) _ inst op(0 rd,1 wr) _ inst addr _ inst wdata _ inst exp
// _ data op _ data addr _ data wdata _ data exp
01_1_0_5_00000000_00000000_0_0_00000000_00000000
02_2_0_0_00000000_00000000_0_A_00000000_00000000
03_1_1_0_11110000_00000000_0_0_00000000_00000000
04_1_1_1_22221111_00000000_0_0_00000000_00000000
05_1_1_2_33332222_00000000_0_0_00000000_00000000
06_1_1_3_44443333_00000000_0_0_00000000_00000000
07_1_0_0_00000000_11110000_0_0_00000000_00000000
08_1_0_1_00000000_22221111_0_0_00000000_00000000
09_1_0_2_00000000_33332222_0_0_00000000_00000000
0A_1_0_3_00000000_44443333_0_0_00000000_00000000
0B_2_0_0_00000000_00000000_1_8_A5A50008_00000000
0C_2_0_0_00000000_00000000_1_9_A5A50009_00000000
0D_2_0_0_00000000_00000000_1_A_A5A5000A_00000000
0E_2_0_0_00000000_00000000_1_B_A5A5000B_00000000
0F_2_0_0_00000000_00000000_0_8_00000000_A5A50008
10_2_0_0_00000000_00000000_0_9_00000000_A5A50009
11_2_0_0_00000000_00000000_0_A_00000000_A5A5000A
12_2_0_0_00000000_00000000_0_B_00000000_A5A5000B
13_3_0_0_00000000_11110000_0_9_00000000_A5A50009
14_3_1_C_C0C0000C_00000000_1_D_D0D0000D_00000000
15_3_0_D_00000000_D0D0000D_0_C_00000000_C0C0000C
16_3_0_6_00000000_5EED0006_1_6_5EED0006_00000000
17_3_0_3_00000000_BEEF0003_1_3_BEEF0003_00000000
18_3_0_3_00000000_BEEF0003_0_6_00000000_5EED0006

// File: flist.f
+incdir+include
logic/storage_bus_pkg.sv
logic/bus_arbiter.sv
logic/block_store.sv
logic/storage_bus_top.sv
verif/clock_gen.sv
verif/storage_bus_checker.sv
verif/storage_bus_sva.sv
verif/storage_bus_tb.sv

// File: Makefile
VERILATOR ?= verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = storage_bus_tb
FLIST     = flist.f
OBJ_DIR   = obj_dir
LOG       = sim.log
FAIL_MSG  = Testbench failed
PASS_MSG  = Testbench passed

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FLIST)

run: compile
	@./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then \
		echo "Simulation reported failure"; \
		exit 1; \
	fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then \
		echo "Simulation ended without a result"; \
		exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
